// ==== axi_lite_slave/axi_lite_slave.sv ====
//////////////////////////////
// AXI4-Lite slave front end
// One transaction at a time per channel; strips the base address and
// hands single-cycle read and write enables to the register files
//////////////////////////////

`timescale 1ns/10ps

module axi_lite_slave #(
    parameter axi_lite_pkg::addr_t base_address = '0
) (
    input  logic                                  S_AXI_ACLK,
    input  logic                                  S_AXI_ARESETN,
    input  axi_lite_pkg::addr_t                   S_AXI_AWADDR,
    input  logic                                  S_AXI_AWVALID,
    output logic                                  S_AXI_AWREADY,
    input  axi_lite_pkg::data_t                   S_AXI_WDATA,
    input  axi_lite_pkg::strb_t                   S_AXI_WSTRB,
    input  logic                                  S_AXI_WVALID,
    output logic                                  S_AXI_WREADY,
    output axi_lite_pkg::resp_t                   S_AXI_BRESP,
    output logic                                  S_AXI_BVALID,
    input  logic                                  S_AXI_BREADY,
    input  axi_lite_pkg::addr_t                   S_AXI_ARADDR,
    input  logic                                  S_AXI_ARVALID,
    output logic                                  S_AXI_ARREADY,
    output axi_lite_pkg::data_t                   S_AXI_RDATA,
    output axi_lite_pkg::resp_t                   S_AXI_RRESP,
    output logic                                  S_AXI_RVALID,
    input  logic                                  S_AXI_RREADY,
    output logic [oq_regs_pkg::offset_width-1:0]  wr_offset,
    output logic                                  wr_addr_hi_zero,
    output axi_lite_pkg::data_t                   wr_data,
    output axi_lite_pkg::strb_t                   wr_strb,
    output logic                                  wr_en,
    output logic [oq_regs_pkg::offset_width-1:0]  rd_offset,
    output logic                                  rd_addr_hi_zero,
    output logic                                  rd_en,
    input  axi_lite_pkg::data_t                   rd_data
);

    axi_lite_pkg::addr_t aw_addr_q;
    axi_lite_pkg::addr_t ar_addr_q;
    logic                wr_accept;
    logic                rd_accept;

    //////////////////////////////
    // Write channel
    //////////////////////////////

    // Address and data must arrive together, and only when no response waits
    assign wr_accept = S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_AWREADY
                       && !S_AXI_WREADY && !S_AXI_BVALID;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            S_AXI_BVALID  <= 1'b0;
        end else begin
            S_AXI_AWREADY <= wr_accept;
            S_AXI_WREADY  <= wr_accept;
            if (wr_en) begin
                S_AXI_BVALID <= 1'b1;
            end else if (S_AXI_BREADY) begin
                S_AXI_BVALID <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_accept) begin
            aw_addr_q <= S_AXI_AWADDR ^ base_address;
            wr_data   <= S_AXI_WDATA;
            wr_strb   <= S_AXI_WSTRB;
        end
    end

    assign wr_en           = S_AXI_AWREADY && S_AXI_WREADY && S_AXI_AWVALID && S_AXI_WVALID;
    assign wr_offset       = aw_addr_q[oq_regs_pkg::offset_width-1:0];
    assign wr_addr_hi_zero = ~|aw_addr_q[axi_lite_pkg::addr_width-1:oq_regs_pkg::offset_width];
    assign S_AXI_BRESP     = axi_lite_pkg::resp_okay;

    //////////////////////////////
    // Read channel
    //////////////////////////////

    assign rd_accept = S_AXI_ARVALID && !S_AXI_ARREADY && !S_AXI_RVALID;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_ARREADY <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
            S_AXI_RDATA   <= '0;
        end else begin
            S_AXI_ARREADY <= rd_accept;
            if (rd_en) begin
                S_AXI_RVALID <= 1'b1;
                S_AXI_RDATA  <= rd_data;
            end else if (S_AXI_RREADY) begin
                S_AXI_RVALID <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_accept) begin
            ar_addr_q <= S_AXI_ARADDR ^ base_address;
        end
    end

    assign rd_en           = S_AXI_ARREADY && S_AXI_ARVALID;
    assign rd_offset       = ar_addr_q[oq_regs_pkg::offset_width-1:0];
    assign rd_addr_hi_zero = ~|ar_addr_q[axi_lite_pkg::addr_width-1:oq_regs_pkg::offset_width];
    assign S_AXI_RRESP     = axi_lite_pkg::resp_okay;

endmodule

// ==== common/axi_lite_pkg.sv ====
//////////////////////////////
// AXI4-Lite slave side widths, data types and response codes
// Shared by the bus slave, the register files and the top level
//////////////////////////////

package axi_lite_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [strb_width-1:0] strb_t;
    typedef logic [1:0]            resp_t;

    // No error responses are produced
    localparam resp_t resp_okay = 2'b00;

endpackage

// ==== common/oq_regs_pkg.sv ====
//////////////////////////////
// Register map of the output queue CPU registers
// Offsets, reset values, identity words and the port statistic layout
// Offsets are relative to the block base address
//////////////////////////////

package oq_regs_pkg;

    localparam int offset_width = 12;

    //////////////////////////////
    // Global registers, region 0
    //////////////////////////////
    localparam logic [offset_width-1:0] reg_id_off      = 12'h000;
    localparam logic [offset_width-1:0] reg_version_off = 12'h004;
    localparam logic [offset_width-1:0] reg_reset_off   = 12'h008;
    localparam logic [offset_width-1:0] reg_flip_off    = 12'h00C;
    localparam logic [offset_width-1:0] reg_debug_off   = 12'h010;
    localparam logic [offset_width-1:0] reg_pktin_off   = 12'h014;
    localparam logic [offset_width-1:0] reg_pktout_off  = 12'h018;

    //////////////////////////////
    // Per port statistics
    //////////////////////////////
    localparam logic [3:0] port_region = 4'd1;
    localparam int         num_stats   = 7;

    localparam int stat_pkt_stored    = 0;
    localparam int stat_bytes_stored  = 1;
    localparam int stat_pkt_removed   = 2;
    localparam int stat_bytes_removed = 3;
    localparam int stat_pkt_dropped   = 4;
    localparam int stat_bytes_dropped = 5;
    localparam int stat_pkt_in_queue  = 6;

    // Identity and reset values
    localparam axi_lite_pkg::data_t id_value       = 32'h0000_DA03;
    localparam axi_lite_pkg::data_t version_value  = 32'h0001_0000;
    localparam axi_lite_pkg::data_t reset_default  = 32'h0000_0000;
    localparam axi_lite_pkg::data_t flip_default   = 32'h0000_0000;
    localparam axi_lite_pkg::data_t debug_default  = 32'h0000_0000;
    localparam axi_lite_pkg::data_t bad_addr_value = 32'hDEAD_BEEF;

    // Port statistic view of an offset, 0x100 + port*0x20 + stat*4
    typedef struct packed {
        logic [3:0] region;
        logic [2:0] port;
        logic [2:0] stat;
        logic [1:0] lane;
    } port_stat_t;

    typedef union packed {
        logic [offset_width-1:0] word;
        port_stat_t              port_stat;
    } reg_offset_u;

endpackage

// ==== compile.f ====
common/axi_lite_pkg.sv
common/oq_regs_pkg.sv
axi_lite_slave/axi_lite_slave.sv
reg_file/oq_reg_write.sv
reg_file/oq_reg_read.sv
hdl/output_queues_cpu_regs.sv
tb/oq_regs_asserts.sv
tb/tb_output_queues_cpu_regs.sv

// ==== hdl/output_queues_cpu_regs.sv ====
//////////////////////////////
// Output queue CPU register block
// AXI4-Lite slave with the write and read register files behind it
//////////////////////////////

`timescale 1ns/10ps

module output_queues_cpu_regs #(
    parameter int                  num_ports    = 5,
    parameter axi_lite_pkg::addr_t base_address = '0
) (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    input  axi_lite_pkg::addr_t S_AXI_AWADDR,
    input  logic                S_AXI_AWVALID,
    output logic                S_AXI_AWREADY,
    input  axi_lite_pkg::data_t S_AXI_WDATA,
    input  axi_lite_pkg::strb_t S_AXI_WSTRB,
    input  logic                S_AXI_WVALID,
    output logic                S_AXI_WREADY,
    output axi_lite_pkg::resp_t S_AXI_BRESP,
    output logic                S_AXI_BVALID,
    input  logic                S_AXI_BREADY,
    input  axi_lite_pkg::addr_t S_AXI_ARADDR,
    input  logic                S_AXI_ARVALID,
    output logic                S_AXI_ARREADY,
    output axi_lite_pkg::data_t S_AXI_RDATA,
    output axi_lite_pkg::resp_t S_AXI_RRESP,
    output logic                S_AXI_RVALID,
    input  logic                S_AXI_RREADY,
    // Counters and their clear pulses
    input  axi_lite_pkg::data_t pktin,
    output logic                pktin_clear,
    input  axi_lite_pkg::data_t pktout,
    output logic                pktout_clear,
    input  logic [num_ports*oq_regs_pkg::num_stats*axi_lite_pkg::data_width-1:0] port_stats,
    output logic [num_ports*oq_regs_pkg::num_stats-1:0] port_stats_clear,
    // Control registers
    input  axi_lite_pkg::data_t ip2cpu_flip,
    output axi_lite_pkg::data_t cpu2ip_flip,
    input  axi_lite_pkg::data_t ip2cpu_debug,
    output axi_lite_pkg::data_t cpu2ip_debug,
    output axi_lite_pkg::data_t reset_pulse
);

    logic [oq_regs_pkg::offset_width-1:0] wr_offset;
    logic                                 wr_addr_hi_zero;
    axi_lite_pkg::data_t                  wr_data;
    axi_lite_pkg::strb_t                  wr_strb;
    logic                                 wr_en;
    logic [oq_regs_pkg::offset_width-1:0] rd_offset;
    logic                                 rd_addr_hi_zero;
    logic                                 rd_en;
    axi_lite_pkg::data_t                  rd_data;

    axi_lite_slave #(
        .base_address (base_address)
    ) u_slave (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .S_AXI_AWADDR, .S_AXI_AWVALID, .S_AXI_AWREADY,
        .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
        .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
        .S_AXI_ARADDR, .S_AXI_ARVALID, .S_AXI_ARREADY,
        .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
        .wr_offset, .wr_addr_hi_zero, .wr_data, .wr_strb, .wr_en,
        .rd_offset, .rd_addr_hi_zero, .rd_en, .rd_data
    );

    oq_reg_write u_write (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .wr_offset, .wr_addr_hi_zero, .wr_data, .wr_strb, .wr_en,
        .reset_pulse, .cpu2ip_flip, .cpu2ip_debug
    );

    oq_reg_read #(
        .num_ports (num_ports)
    ) u_read (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .rd_offset, .rd_addr_hi_zero, .rd_en, .rd_data,
        .ip2cpu_flip, .ip2cpu_debug,
        .pktin, .pktout, .port_stats,
        .pktin_clear, .pktout_clear, .port_stats_clear
    );

endmodule

// ==== reg_file/oq_reg_read.sv ====
//////////////////////////////
// Read side of the register map
// Combinational read mux, plus clear-on-read pulses for the counters
// Clear bit fires two cycles after the read enable
//////////////////////////////

`timescale 1ns/10ps

module oq_reg_read #(
    parameter int num_ports = 5
) (
    input  logic                                  S_AXI_ACLK,
    input  logic                                  S_AXI_ARESETN,
    input  logic [oq_regs_pkg::offset_width-1:0]  rd_offset,
    input  logic                                  rd_addr_hi_zero,
    input  logic                                  rd_en,
    output axi_lite_pkg::data_t                   rd_data,
    input  axi_lite_pkg::data_t                   ip2cpu_flip,
    input  axi_lite_pkg::data_t                   ip2cpu_debug,
    input  axi_lite_pkg::data_t                   pktin,
    input  axi_lite_pkg::data_t                   pktout,
    input  logic [num_ports*oq_regs_pkg::num_stats*axi_lite_pkg::data_width-1:0] port_stats,
    output logic                                  pktin_clear,
    output logic                                  pktout_clear,
    output logic [num_ports*oq_regs_pkg::num_stats-1:0] port_stats_clear
);

    localparam int num_cnt = num_ports * oq_regs_pkg::num_stats;

    oq_regs_pkg::reg_offset_u off;
    logic                     port_hit;
    // Bit 0 pktin, bit 1 pktout, then the port statistics port-major
    logic [num_cnt+1:0]       cnt_sel;
    logic [num_cnt+1:0]       clear_d1;
    logic [num_cnt+1:0]       clear_d2;

    assign off = rd_offset;

    assign port_hit = rd_addr_hi_zero
                      && (off.port_stat.region == oq_regs_pkg::port_region)
                      && (int'(off.port_stat.port) < num_ports)
                      && (int'(off.port_stat.stat) < oq_regs_pkg::num_stats)
                      && (off.port_stat.lane == 2'b00);

    always_comb begin
        int unsigned idx;
        idx     = off.port_stat.port * oq_regs_pkg::num_stats + off.port_stat.stat;
        rd_data = oq_regs_pkg::bad_addr_value;
        cnt_sel = '0;
        if (port_hit) begin
            rd_data        = port_stats[idx*axi_lite_pkg::data_width +: axi_lite_pkg::data_width];
            cnt_sel[idx+2] = 1'b1;
        end else if (rd_addr_hi_zero) begin
            case (off.word)
                oq_regs_pkg::reg_id_off:      rd_data = oq_regs_pkg::id_value;
                oq_regs_pkg::reg_version_off: rd_data = oq_regs_pkg::version_value;
                oq_regs_pkg::reg_flip_off:    rd_data = ip2cpu_flip;
                oq_regs_pkg::reg_debug_off:   rd_data = ip2cpu_debug;
                oq_regs_pkg::reg_pktin_off: begin
                    rd_data    = pktin;
                    cnt_sel[0] = 1'b1;
                end
                oq_regs_pkg::reg_pktout_off: begin
                    rd_data    = pktout;
                    cnt_sel[1] = 1'b1;
                end
                default: rd_data = oq_regs_pkg::bad_addr_value;
            endcase
        end
    end

    //////////////////////////////
    // Clear pulse pipeline
    //////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            clear_d1 <= '0;
            clear_d2 <= '0;
        end else begin
            clear_d1 <= rd_en ? cnt_sel : '0;
            clear_d2 <= clear_d1;
        end
    end

    assign pktin_clear      = clear_d2[0];
    assign pktout_clear     = clear_d2[1];
    assign port_stats_clear = clear_d2[num_cnt+1:2];

endmodule

// ==== reg_file/oq_reg_write.sv ====
//////////////////////////////
// Writable registers: reset pulse, flip and debug
// Updated on wr_en under the byte strobes
//////////////////////////////

`timescale 1ns/10ps

module oq_reg_write (
    input  logic                                  S_AXI_ACLK,
    input  logic                                  S_AXI_ARESETN,
    input  logic [oq_regs_pkg::offset_width-1:0]  wr_offset,
    input  logic                                  wr_addr_hi_zero,
    input  axi_lite_pkg::data_t                   wr_data,
    input  axi_lite_pkg::strb_t                   wr_strb,
    input  logic                                  wr_en,
    output axi_lite_pkg::data_t                   reset_pulse,
    output axi_lite_pkg::data_t                   cpu2ip_flip,
    output axi_lite_pkg::data_t                   cpu2ip_debug
);

    logic wr_reset;
    logic wr_flip;
    logic wr_debug;

    // Take the strobed bytes from new_val, the rest from old_val
    function automatic axi_lite_pkg::data_t byte_merge(
        input axi_lite_pkg::data_t old_val,
        input axi_lite_pkg::data_t new_val,
        input axi_lite_pkg::strb_t strb
    );
        axi_lite_pkg::data_t res;
        res = old_val;
        for (int i = 0; i < axi_lite_pkg::strb_width; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign wr_reset = wr_en && wr_addr_hi_zero && (wr_offset == oq_regs_pkg::reg_reset_off);
    assign wr_flip  = wr_en && wr_addr_hi_zero && (wr_offset == oq_regs_pkg::reg_flip_off);
    assign wr_debug = wr_en && wr_addr_hi_zero && (wr_offset == oq_regs_pkg::reg_debug_off);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            reset_pulse  <= oq_regs_pkg::reset_default;
            cpu2ip_flip  <= oq_regs_pkg::flip_default;
            cpu2ip_debug <= oq_regs_pkg::debug_default;
        end else begin
            // Event register, back to default one cycle after the write
            if (wr_reset) begin
                reset_pulse <= byte_merge(oq_regs_pkg::reset_default, wr_data, wr_strb);
            end else begin
                reset_pulse <= oq_regs_pkg::reset_default;
            end
            if (wr_flip) begin
                cpu2ip_flip <= byte_merge(cpu2ip_flip, wr_data, wr_strb);
            end
            if (wr_debug) begin
                cpu2ip_debug <= byte_merge(cpu2ip_debug, wr_data, wr_strb);
            end
        end
    end

endmodule

// ==== tb/oq_regs_asserts.sv ====
//////////////////////////////
// Protocol and pulse checks for the output queue register block
// Bound to the top level, reports only through failing assertions
//////////////////////////////

`timescale 1ns/10ps

module oq_regs_asserts #(
    parameter int num_ports = 5
) (
    input logic                clk,
    input logic                rstn,
    input logic                bvalid,
    input logic                bready,
    input axi_lite_pkg::resp_t bresp,
    input logic                rvalid,
    input logic                rready,
    input axi_lite_pkg::resp_t rresp,
    input axi_lite_pkg::data_t rdata,
    input logic [num_ports*oq_regs_pkg::num_stats+1:0] clr
);

    // Responses hold until accepted
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid) else $error("BVALID dropped before BREADY");
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("RVALID or RDATA changed before RREADY");

    a_bresp_okay: assert property (@(posedge clk) disable iff (!rstn)
        bvalid |-> bresp == axi_lite_pkg::resp_okay) else $error("BRESP not OKAY");
    a_rresp_okay: assert property (@(posedge clk) disable iff (!rstn)
        rvalid |-> rresp == axi_lite_pkg::resp_okay) else $error("RRESP not OKAY");

    // Single cycle clear pulses
    a_clr_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        clr != '0 |=> (clr & $past(clr)) == '0) else $error("clear bit held two cycles");

endmodule

bind output_queues_cpu_regs oq_regs_asserts #(.num_ports(num_ports)) u_asserts (
    .clk    (S_AXI_ACLK),
    .rstn   (S_AXI_ARESETN),
    .bvalid (S_AXI_BVALID),
    .bready (S_AXI_BREADY),
    .bresp  (S_AXI_BRESP),
    .rvalid (S_AXI_RVALID),
    .rready (S_AXI_RREADY),
    .rresp  (S_AXI_RRESP),
    .rdata  (S_AXI_RDATA),
    .clr    ({port_stats_clear, pktout_clear, pktin_clear})
);

// ==== tb/tb_output_queues_cpu_regs.sv ====
//////////////////////////////
// Testbench for the output queue register block
// Drives AXI4-Lite reads and writes and checks them against a register model
//////////////////////////////

`timescale 1ns/10ps

module tb_output_queues_cpu_regs;

    localparam int num_ports = 5;
    localparam int ns = oq_regs_pkg::num_stats;
    localparam int nc = num_ports * ns + 2;
    localparam axi_lite_pkg::addr_t base = 32'h4400_0000;
    // Generous cycle budget per transaction
    localparam int n_xfers = 64 + num_ports * ns;
    localparam int timeout_cycles = n_xfers * 200;

    logic S_AXI_ACLK, S_AXI_ARESETN;
    axi_lite_pkg::addr_t S_AXI_AWADDR, S_AXI_ARADDR;
    axi_lite_pkg::data_t S_AXI_WDATA, S_AXI_RDATA;
    axi_lite_pkg::strb_t S_AXI_WSTRB;
    axi_lite_pkg::resp_t S_AXI_BRESP, S_AXI_RRESP;
    logic S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
    logic S_AXI_RVALID, S_AXI_RREADY;
    axi_lite_pkg::data_t pktin, pktout, ip2cpu_flip, ip2cpu_debug;
    axi_lite_pkg::data_t cpu2ip_flip, cpu2ip_debug, reset_pulse;
    logic pktin_clear, pktout_clear;
    logic [num_ports*ns*32-1:0] port_stats;
    logic [num_ports*ns-1:0] port_stats_clear;

    integer seed;
    int errors, checks, cyc, ar_cyc, pulse_cnt, tests;
    axi_lite_pkg::data_t pulse_val, flip_m, debug_m;
    axi_lite_pkg::data_t exp_q[$];
    logic [nc-1:0] clr_q[$];
    int clr_cyc_q[$];

    output_queues_cpu_regs #(.num_ports(num_ports), .base_address(base)) DUT (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        repeat (timeout_cycles) @(posedge S_AXI_ACLK);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    always @(posedge S_AXI_ACLK) cyc <= cyc + 1;

    // Monitor of accepted reads, clear pulses and the reset pulse
    always @(negedge S_AXI_ACLK) begin
        if (S_AXI_ARREADY) ar_cyc = cyc;
        if ({port_stats_clear, pktout_clear, pktin_clear} != '0) begin
            clr_q.push_back({port_stats_clear, pktout_clear, pktin_clear});
            clr_cyc_q.push_back(cyc);
        end
        if (reset_pulse != '0) begin
            pulse_cnt++;
            pulse_val = reset_pulse;
        end
    end

    // Compares each accepted read against the model
    always @(negedge S_AXI_ACLK) begin
        if (S_AXI_RVALID && S_AXI_RREADY) begin
            if (exp_q.size() == 0) report_error("read data returned with no read outstanding");
            else check_data("S_AXI_RDATA", exp_q.pop_front(), S_AXI_RDATA);
            check_resp("S_AXI_RRESP", axi_lite_pkg::resp_okay, S_AXI_RRESP);
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic check_data(input string name, input axi_lite_pkg::data_t exp, got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("MISMATCH %s expected %08h got %08h", name, exp, got);
        end
    endtask

    task automatic check_resp(input string name, input axi_lite_pkg::resp_t exp, got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("MISMATCH %s expected %01h got %01h", name, exp, got);
        end
    endtask

    task automatic check_clear(input string name, input logic [nc-1:0] exp, got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("MISMATCH %s expected %0h got %0h", name, exp, got);
        end
    endtask

    function automatic axi_lite_pkg::data_t merge_bytes(input axi_lite_pkg::data_t old_v,
            input axi_lite_pkg::data_t new_v, input axi_lite_pkg::strb_t strb);
        axi_lite_pkg::data_t r;
        r = old_v;
        for (int i = 0; i < 4; i++) if (strb[i]) r[8*i +: 8] = new_v[8*i +: 8];
        return r;
    endfunction

    function automatic axi_lite_pkg::addr_t stat_addr(input int port, input int stat);
        return base ^ (32'h100 + port * 32'h20 + stat * 4);
    endfunction

    // Expected read value and clear vector from the register map rules
    function automatic axi_lite_pkg::data_t expected_read(input axi_lite_pkg::addr_t addr,
            output logic [nc-1:0] clr);
        axi_lite_pkg::addr_t off;
        int port, stat;
        off = addr ^ base;
        clr = '0;
        port = off[7:5];
        stat = off[4:2];
        if (off[31:12] != 0) return oq_regs_pkg::bad_addr_value;
        if (off[11:8] == 1 && port < num_ports && stat < ns && off[1:0] == 0) begin
            clr[2 + port * ns + stat] = 1'b1;
            return port_stats[(port * ns + stat) * 32 +: 32];
        end
        case (off[11:0])
            oq_regs_pkg::reg_id_off:      return oq_regs_pkg::id_value;
            oq_regs_pkg::reg_version_off: return oq_regs_pkg::version_value;
            oq_regs_pkg::reg_flip_off:    return ip2cpu_flip;
            oq_regs_pkg::reg_debug_off:   return ip2cpu_debug;
            oq_regs_pkg::reg_pktin_off: begin
                clr[0] = 1'b1;
                return pktin;
            end
            oq_regs_pkg::reg_pktout_off: begin
                clr[1] = 1'b1;
                return pktout;
            end
            default: return oq_regs_pkg::bad_addr_value;
        endcase
    endfunction

    task automatic axi_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
            input axi_lite_pkg::strb_t strb, input int stall, output axi_lite_pkg::resp_t resp);
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_AWADDR = addr;
        S_AXI_WDATA = data;
        S_AXI_WSTRB = strb;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID = 1'b1;
        do @(negedge S_AXI_ACLK); while (!S_AXI_AWREADY && !S_AXI_WREADY);
        if (!(S_AXI_AWREADY && S_AXI_WREADY)) begin
            report_error("AWREADY and WREADY not raised together");
        end
        @(posedge S_AXI_ACLK);
        #1;
        // Valids stay up during a stall to probe back-pressure
        for (int i = 0; i < stall; i++) begin
            @(negedge S_AXI_ACLK);
            if (!S_AXI_BVALID) report_error("BVALID dropped while BREADY was low");
            if (S_AXI_AWREADY || S_AXI_WREADY) begin
                report_error("write address accepted while BVALID pending");
            end
            @(posedge S_AXI_ACLK);
            #1;
        end
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID = 1'b0;
        S_AXI_BREADY = 1'b1;
        do @(negedge S_AXI_ACLK); while (!S_AXI_BVALID);
        resp = S_AXI_BRESP;
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axi_read(input axi_lite_pkg::addr_t addr, input int stall,
            output axi_lite_pkg::data_t data, output axi_lite_pkg::resp_t resp);
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARADDR = addr;
        S_AXI_ARVALID = 1'b1;
        do @(negedge S_AXI_ACLK); while (!S_AXI_ARREADY);
        @(posedge S_AXI_ACLK);
        #1;
        for (int i = 0; i < stall; i++) begin
            @(negedge S_AXI_ACLK);
            if (!S_AXI_RVALID) report_error("RVALID dropped while RREADY was low");
            if (S_AXI_ARREADY) report_error("read address accepted while RVALID pending");
            @(posedge S_AXI_ACLK);
            #1;
        end
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY = 1'b1;
        do @(negedge S_AXI_ACLK); while (!S_AXI_RVALID);
        data = S_AXI_RDATA;
        resp = S_AXI_RRESP;
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic read_and_check(input axi_lite_pkg::addr_t addr, input int stall);
        axi_lite_pkg::data_t got;
        axi_lite_pkg::resp_t resp;
        logic [nc-1:0] exp_clr, obs_clr;
        exp_q.push_back(expected_read(addr, exp_clr));
        clr_q.delete();
        clr_cyc_q.delete();
        axi_read(addr, stall, got, resp);
        repeat (3) @(negedge S_AXI_ACLK);
        obs_clr = '0;
        if (clr_q.size() > 1) begin
            report_error("more than one clear pulse for a single read");
        end else if (clr_q.size() == 1) begin
            obs_clr = clr_q[0];
            if (clr_cyc_q[0] != ar_cyc + 2) begin
                report_error("clear pulse not two cycles after ARREADY");
            end
        end
        check_clear("clear", exp_clr, obs_clr);
    endtask

    task automatic write_and_check(input axi_lite_pkg::addr_t addr,
            input axi_lite_pkg::data_t data, input axi_lite_pkg::strb_t strb, input int stall);
        axi_lite_pkg::resp_t resp;
        axi_lite_pkg::data_t exp_pulse;
        exp_pulse = '0;
        pulse_cnt = 0;
        axi_write(addr, data, strb, stall, resp);
        check_resp("S_AXI_BRESP", axi_lite_pkg::resp_okay, resp);
        case ((addr ^ base))
            oq_regs_pkg::reg_flip_off:  flip_m = merge_bytes(flip_m, data, strb);
            oq_regs_pkg::reg_debug_off: debug_m = merge_bytes(debug_m, data, strb);
            oq_regs_pkg::reg_reset_off: exp_pulse = merge_bytes('0, data, strb);
            default: ;
        endcase
        repeat (2) @(negedge S_AXI_ACLK);
        check_data("cpu2ip_flip", flip_m, cpu2ip_flip);
        check_data("cpu2ip_debug", debug_m, cpu2ip_debug);
        if (pulse_cnt != (exp_pulse != '0)) report_error("reset_pulse not high for one cycle");
        else if (exp_pulse != '0) check_data("reset_pulse", exp_pulse, pulse_val);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        int e;
        seed = 32'h84c4;
        {errors, checks, cyc, ar_cyc, pulse_cnt, tests} = '0;
        {flip_m, debug_m, pulse_val} = '0;
        S_AXI_ARESETN = 1'b0;
        {S_AXI_AWADDR, S_AXI_ARADDR, S_AXI_WDATA, S_AXI_WSTRB} = '0;
        {S_AXI_AWVALID, S_AXI_WVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_RREADY} = '0;
        for (int i = 0; i < num_ports * ns; i++) port_stats[i*32 +: 32] = $random(seed);
        pktin = $random(seed);
        pktout = $random(seed);
        ip2cpu_flip = $random(seed);
        ip2cpu_debug = $random(seed);
        repeat (10) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        e = errors;
        check_data("S_AXI_RDATA", '0, S_AXI_RDATA);
        read_and_check(base ^ oq_regs_pkg::reg_id_off, 0);
        read_and_check(base ^ oq_regs_pkg::reg_version_off, 0);
        end_test("identity", e);

        e = errors;
        for (int i = 0; i < 8; i++) begin
            write_and_check(base ^ oq_regs_pkg::reg_flip_off, $random(seed), $random(seed), 0);
            write_and_check(base ^ oq_regs_pkg::reg_debug_off, $random(seed), $random(seed), 0);
        end
        read_and_check(base ^ oq_regs_pkg::reg_flip_off, 0);
        read_and_check(base ^ oq_regs_pkg::reg_debug_off, 0);
        end_test("flip and debug", e);

        e = errors;
        write_and_check(base ^ oq_regs_pkg::reg_reset_off, 32'hA5A5_0001, 4'hF, 0);
        write_and_check(base ^ oq_regs_pkg::reg_reset_off, $random(seed) | 32'h0101_0101,
                        4'h5, 0);
        end_test("reset pulse", e);

        e = errors;
        for (int p = 0; p < num_ports; p++)
            for (int s = 0; s < ns; s++) read_and_check(stat_addr(p, s), 0);
        read_and_check(base ^ oq_regs_pkg::reg_pktin_off, 0);
        read_and_check(base ^ oq_regs_pkg::reg_pktout_off, 0);
        end_test("statistics", e);

        e = errors;
        if (num_ports < 8) read_and_check(stat_addr(num_ports, 0), 0);
        read_and_check(stat_addr(0, 7), 0);
        read_and_check(base ^ 32'h01C, 0);
        read_and_check(base ^ 32'h1000, 0);
        end_test("unmapped", e);

        e = errors;
        for (int i = 0; i < 4; i++) begin
            write_and_check(base ^ oq_regs_pkg::reg_flip_off, $random(seed), 4'hF,
                            ($random(seed) & 15) + 1);
            read_and_check(stat_addr(i % num_ports, i + 2), ($random(seed) & 15) + 1);
        end
        end_test("back-pressure", e);

        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
